// File: Makefile
TOP := tb_dac_playback

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: compile.f
+incdir+.
dac_pkg.sv
dac_sample_buf.sv
dac_rate_stepper.sv
dac_volume_scaler.sv
dac_i2s_serializer.sv
dac_playback_top.sv
dac_playback_checker.sv
tb_dac_playback.sv

// File: dac_defines.svh
`ifndef DAC_DEFINES_SVH
`define DAC_DEFINES_SVH

////////////////////////////////////////////////////////////////////////
// Rate stepper
////////////////////////////////////////////////////////////////////////
`define DAC_ACC_BITS 26          // Fractional accumulator width
`define DAC_RATE_INC 122500      // Added per sysclk rising edge
`define DAC_RATE_WRAP 59501439   // Subtracted on overflow

////////////////////////////////////////////////////////////////////////
// Serializer divider taps
////////////////////////////////////////////////////////////////////////
`define DAC_MCLK_BIT 2           // clkin / 8
`define DAC_BCLK_BIT 5           // 16 bit clocks per half frame
`define DAC_LRCK_BIT 10          // 2048 clkin per frame

// One volume step every 2**N frames
`define DAC_RAMP_FRAMES_LOG2 2

`endif

// File: dac_i2s_serializer.sv
`timescale 1ns/1ps
`include "dac_defines.svh"

module dac_i2s_serializer import dac_pkg::*; (
	input  logic    clkin,
	input  logic    reset_rising,
	input  sample_t chan_sample,
	input  logic    load,
	output logic    lrck_rise,
	output logic    lrck_fall,
	output logic    mclk,
	output logic    bclk,
	output logic    lrck,
	output logic    sdout
);

	logic [15:0] div_cnt;
	logic [2:0]  lrck_sreg;
	logic [2:0]  bclk_sreg;
	logic        bclk_rise;
	sample_t     shift;

	////////////////////////////////////////////////////////////////////////
	// Clock divider
	////////////////////////////////////////////////////////////////////////
	assign mclk = div_cnt[`DAC_MCLK_BIT];
	assign bclk = div_cnt[`DAC_BCLK_BIT];
	assign lrck = div_cnt[`DAC_LRCK_BIT]; // High for the right half

	always_ff @(posedge clkin) begin
		if (reset_rising) begin
			div_cnt <= '0;
			lrck_sreg <= '0;
			bclk_sreg <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			lrck_sreg <= {lrck_sreg[1:0], lrck};
			bclk_sreg <= {bclk_sreg[1:0], bclk};
		end
	end

	// Edge pulses, two cycles behind the clocks
	assign lrck_rise = (lrck_sreg[2:1] == 2'b01);
	assign lrck_fall = (lrck_sreg[2:1] == 2'b10);
	assign bclk_rise = (bclk_sreg[2:1] == 2'b01);

	////////////////////////////////////////////////////////////////////////
	// Shift register, MSB first, zeros after bit 0
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clkin) begin
		if (reset_rising) begin
			shift <= '0;
			sdout <= 1'b0;
		end else if (load) begin
			shift <= chan_sample;
		end else if (bclk_rise) begin
			sdout <= shift[15];
			shift <= {shift[14:0], 1'b0};
		end
	end

	// A load landing on a bit edge would drop one bit
	a_load_vs_bclk: assert property (@(posedge clkin) disable iff (reset_rising)
		!(load && bclk_rise));

endmodule

// File: dac_pkg.sv
package dac_pkg;

	// One audio sample, two's complement
	typedef logic [15:0] sample_t;

	// Buffer word, right sample in [31:16], left in [15:0]
	typedef logic [31:0] frame_t;

	// Unsigned volume, 255 is just below unity
	typedef logic [7:0] vol_t;

	// Playback word address, top bit reported as half-buffer status
	typedef logic [8:0] buf_addr_t;

	// Host byte address into the 2 KB buffer
	typedef logic [10:0] pgm_addr_t;

endpackage

// File: dac_playback_checker.sv
`timescale 1ns/1ps
`include "dac_defines.svh"

module dac_playback_checker import dac_pkg::*; (
	input  logic       clkin,
	input  logic       reset_rising,
	input  logic       sysclk,
	input  logic       play,
	input  logic       pgm_we_n,
	input  pgm_addr_t  pgm_address,
	input  logic [7:0] pgm_data,
	input  vol_t       volume,
	input  logic       vol_latch,
	input  logic       sdout,
	input  logic       lrck,
	input  logic       bclk,
	input  logic       mclk,
	input  logic       dac_status,
	output int         error_count,
	output int         sample_count
);

	logic [7:0]  mem [0:2047];  // Mirror of the host writes
	int unsigned acc;
	int unsigned div;           // Divider count since reset
	logic [2:0]  clk_exp;
	buf_addr_t   addr;
	vol_t        vol;
	vol_t        target;
	int          rise_cnt;      // Word clock rises since reset
	logic [1:0]  pend;          // sysclk rises waiting to reach the accumulator
	logic        play_q, sys_q, latch_q, lrck_q, bclk_q;
	logic        ready, half_valid;
	sample_t     cap;
	sample_t     exp_sample;
	frame_t      word;

	// Offset binary times volume, top 16 bits of 24, back to signed
	function automatic sample_t ref_scale(input sample_t s, input vol_t v);
		int unsigned off;
		int unsigned prod;
		off = (int'(s) + 32768) % 65536;
		prod = off * int'(v);
		return sample_t'(int'(prod / 256) - 32768);
	endfunction

	function automatic vol_t ramp_toward(input vol_t cur, input vol_t tgt);
		if (cur < tgt)
			return cur + 8'd1;
		if (cur > tgt)
			return cur - 8'd1;
		return cur;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		error_count = error_count + 1;
		$display("CHECK FAILED %s expected %0h got %0h at %0t", name, exp_v, act_v, $time);
	endtask

	initial begin
		error_count = 0;
		sample_count = 0;
		ready = 1'b0;
		pend = 2'b00;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and comparison
	//////////////////////////////////////////////////////////////////////
	always @(posedge clkin) begin
		if (ready && reset_rising && ({sdout, lrck, bclk, mclk, dac_status} !== 5'b0))
			report_mismatch("sdout,lrck,bclk,mclk,dac_status", 0,
				{sdout, lrck, bclk, mclk, dac_status});
		clk_exp = {div[`DAC_LRCK_BIT], div[`DAC_BCLK_BIT], div[`DAC_MCLK_BIT]};
		if (ready && ({lrck, bclk, mclk} !== clk_exp))
			report_mismatch("lrck,bclk,mclk", clk_exp, {lrck, bclk, mclk});
		if (ready && (dac_status !== addr[8]))
			report_mismatch("dac_status", addr[8], dac_status);
		if (reset_rising) begin
			acc = 0;
			div = 0;
			addr = '0;
			vol = 8'h00;
			target = 8'hff;
			rise_cnt = 0;
			half_valid = 1'b0;
			ready = 1'b1;
		end else begin
			div = div + 1;
			if (!pgm_we_n)
				mem[pgm_address] = pgm_data;
			if (pend[1]) begin
				if (acc > `DAC_RATE_WRAP - `DAC_RATE_INC - 1) begin
					acc = acc + `DAC_RATE_INC - `DAC_RATE_WRAP;
					addr = addr + buf_addr_t'(play_q); // Steps only with play
				end else begin
					acc = acc + `DAC_RATE_INC;
				end
			end
			if (vol_latch && !latch_q)
				target = volume;
			if (!bclk && bclk_q)
				cap = {cap[14:0], sdout}; // MSB first
			if (lrck != lrck_q) begin
				if (half_valid) begin
					sample_count = sample_count + 1;
					if (cap !== exp_sample)
						report_mismatch(lrck_q ? "sdout right" : "sdout left", exp_sample, cap);
				end
				word = {mem[{addr, 2'd3}], mem[{addr, 2'd2}],
					mem[{addr, 2'd1}], mem[{addr, 2'd0}]};
				if (lrck) begin
					exp_sample = ref_scale(word[31:16], vol); // Right before the step
					if (rise_cnt % 4 == 3)
						vol = ramp_toward(vol, target);
					rise_cnt = rise_cnt + 1;
				end else begin
					exp_sample = ref_scale(word[15:0], vol);
				end
				half_valid = 1'b1;
			end
		end
		pend = {pend[0], sysclk && !sys_q}; // Edge seen here, applied two clocks on
		play_q = play;
		sys_q = sysclk;
		latch_q = vol_latch;
		lrck_q = lrck;
		bclk_q = bclk;
	end

endmodule

// File: dac_playback_top.sv
`timescale 1ns/1ps

module dac_playback_top import dac_pkg::*; (
	input  logic       clkin,
	input  logic       reset_rising,
	input  logic       sysclk,
	input  logic       pgm_we_n,
	input  pgm_addr_t  pgm_address,
	input  logic [7:0] pgm_data,
	input  vol_t       volume,
	input  logic       vol_latch,
	input  logic       play,
	output logic       sdout,
	output logic       lrck,
	output logic       bclk,
	output logic       mclk,
	output logic       dac_status
);

	buf_addr_t buf_addr;
	frame_t    frame;
	logic      lrck_rise;
	logic      lrck_fall;
	sample_t   chan_sample;
	logic      load;

	// Playback buffer, host writes bytes and playback reads words
	dac_sample_buf u_buf (
		.clkin(clkin), .pgm_we_n(pgm_we_n), .pgm_address(pgm_address),
		.pgm_data(pgm_data), .buf_addr(buf_addr), .frame(frame)
	);

	// Decode
	dac_rate_stepper u_stepper (
		.clkin(clkin), .reset_rising(reset_rising), .sysclk(sysclk), .play(play),
		.buf_addr(buf_addr), .dac_status(dac_status)
	);

	// Execute
	dac_volume_scaler u_scaler (
		.clkin(clkin), .reset_rising(reset_rising), .volume(volume),
		.vol_latch(vol_latch), .frame(frame), .lrck_rise(lrck_rise),
		.lrck_fall(lrck_fall), .chan_sample(chan_sample), .load(load)
	);

	// Result
	dac_i2s_serializer u_serializer (
		.clkin(clkin), .reset_rising(reset_rising), .chan_sample(chan_sample),
		.load(load), .lrck_rise(lrck_rise), .lrck_fall(lrck_fall),
		.mclk(mclk), .bclk(bclk), .lrck(lrck), .sdout(sdout)
	);

endmodule

// File: dac_rate_stepper.sv
`timescale 1ns/1ps
`include "dac_defines.svh"

module dac_rate_stepper import dac_pkg::*; (
	input  logic      clkin,
	input  logic      reset_rising,
	input  logic      sysclk,
	input  logic      play,
	output buf_addr_t buf_addr,
	output logic      dac_status
);

	localparam int acc_w = `DAC_ACC_BITS;
	localparam logic [acc_w-1:0] acc_inc = acc_w'(`DAC_RATE_INC);
	localparam logic [acc_w-1:0] acc_wrap = acc_w'(`DAC_RATE_WRAP);
	localparam logic [acc_w-1:0] acc_limit = acc_wrap - acc_inc - 1'b1;

	logic [2:0]       sysclk_sync; // Three flop synchronizer
	logic             sysclk_rise;
	logic             play_r;
	logic [acc_w-1:0] acc;

	assign sysclk_rise = (sysclk_sync[2:1] == 2'b01);
	assign dac_status = buf_addr[8]; // Half the host may not touch

	always_ff @(posedge clkin) begin
		sysclk_sync <= {sysclk_sync[1:0], sysclk};
		play_r <= play;
	end

	////////////////////////////////////////////////////////////////////////
	// Fractional accumulator paces the word address
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clkin) begin
		if (reset_rising) begin
			acc <= '0;
			buf_addr <= '0;
		end else if (sysclk_rise) begin
			if (acc > acc_limit) begin
				acc <= acc + acc_inc - acc_wrap; // Wrap and keep the remainder
				buf_addr <= buf_addr + buf_addr_t'(play_r);
			end else begin
				acc <= acc + acc_inc;
			end
		end
	end

	// Address steps by one only, and only with play held
	a_addr_step: assert property (@(posedge clkin) disable iff (reset_rising)
		(buf_addr != $past(buf_addr)) |->
			(buf_addr == buf_addr_t'($past(buf_addr) + 1'b1)) && $past(play_r));

endmodule

// File: dac_sample_buf.sv
`timescale 1ns/1ps

module dac_sample_buf import dac_pkg::*; (
	input  logic      clkin,
	input  logic      pgm_we_n,
	input  pgm_addr_t pgm_address,
	input  logic [7:0] pgm_data,
	input  buf_addr_t buf_addr,
	output frame_t    frame
);

	// One byte lane per array, lane 0 is the LSB of the word
	logic [7:0] lane0 [0:511];
	logic [7:0] lane1 [0:511];
	logic [7:0] lane2 [0:511];
	logic [7:0] lane3 [0:511];

	buf_addr_t  wr_word;
	logic [1:0] wr_lane;

	assign wr_word = pgm_address[10:2];
	assign wr_lane = pgm_address[1:0];

	// Host write port
	always_ff @(posedge clkin) begin
		if (!pgm_we_n) begin
			case (wr_lane)
				2'd0: lane0[wr_word] <= pgm_data;
				2'd1: lane1[wr_word] <= pgm_data;
				2'd2: lane2[wr_word] <= pgm_data;
				default: lane3[wr_word] <= pgm_data;
			endcase
		end
	end

	// Playback read port, one cycle latency
	always_ff @(posedge clkin) begin
		frame <= {lane3[buf_addr], lane2[buf_addr], lane1[buf_addr], lane0[buf_addr]};
	end

endmodule

// File: dac_volume_scaler.sv
`timescale 1ns/1ps
`include "dac_defines.svh"

module dac_volume_scaler import dac_pkg::*; (
	input  logic    clkin,
	input  logic    reset_rising,
	input  vol_t    volume,
	input  logic    vol_latch,
	input  frame_t  frame,
	input  logic    lrck_rise,
	input  logic    lrck_fall,
	output sample_t chan_sample,
	output logic    load
);

	logic [1:0] vol_latch_reg;
	logic       vol_latch_rise;
	logic       vol_valid;
	vol_t       vol_target;
	vol_t       vol;
	logic [`DAC_RAMP_FRAMES_LOG2-1:0] frame_cnt;

	assign vol_latch_rise = (vol_latch_reg == 2'b01);

	// Offset binary, scale, back to two's complement
	function automatic sample_t scale(input sample_t s, input vol_t v);
		logic [23:0] prod;
		prod = {8'h00, s ^ 16'h8000} * {16'h0000, v};
		return prod[23:8] ^ 16'h8000;
	endfunction

	////////////////////////////////////////////////////////////////////////
	// Target latch and ramp
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clkin) begin
		if (reset_rising) begin
			vol_latch_reg <= 2'b00;
			vol_valid <= 1'b0;
			vol_target <= 8'hff;
			vol <= 8'h00;
			frame_cnt <= '0;
		end else begin
			vol_latch_reg <= {vol_latch_reg[0], vol_latch};
			if (vol_latch_rise) begin
				vol_valid <= 1'b1;
			end else if (vol_valid) begin
				vol_target <= volume; // Taken one cycle after the edge
				vol_valid <= 1'b0;
			end
			if (lrck_rise) begin
				frame_cnt <= frame_cnt + 1'b1;
				if (&frame_cnt) begin
					if (vol > vol_target)
						vol <= vol - 1'b1;
					else if (vol < vol_target)
						vol <= vol + 1'b1;
				end
			end
		end
	end

	// Right on the rising word clock, left on the falling one
	always_ff @(posedge clkin) begin
		if (lrck_rise)
			chan_sample <= scale(frame[31:16], vol); // Volume before any step
		else if (lrck_fall)
			chan_sample <= scale(frame[15:0], vol);
	end

	always_ff @(posedge clkin) begin
		if (reset_rising)
			load <= 1'b0;
		else
			load <= lrck_rise | lrck_fall;
	end

	// Volume moves one step at a time, only at a frame start
	a_vol_ramp: assert property (@(posedge clkin) disable iff (reset_rising)
		(vol != $past(vol)) |-> $past(lrck_rise) &&
			((vol_t'(vol - $past(vol)) == 8'd1) || (vol_t'($past(vol) - vol) == 8'd1)));

endmodule

// File: tb_dac_playback.sv
`timescale 1ns/1ps

module tb_dac_playback import dac_pkg::*; ();

	logic       clkin;
	logic       reset_rising;
	logic       sysclk;
	logic       pgm_we_n;
	pgm_addr_t  pgm_address;
	logic [7:0] pgm_data;
	vol_t       volume;
	logic       vol_latch;
	logic       play;
	logic       sdout, lrck, bclk, mclk, dac_status;
	int         error_count;
	int         sample_count;

	dac_playback_top u_dac_playback_top (
		.clkin(clkin), .reset_rising(reset_rising), .sysclk(sysclk),
		.pgm_we_n(pgm_we_n), .pgm_address(pgm_address), .pgm_data(pgm_data),
		.volume(volume), .vol_latch(vol_latch), .play(play), .sdout(sdout),
		.lrck(lrck), .bclk(bclk), .mclk(mclk), .dac_status(dac_status)
	);

	dac_playback_checker u_checker (
		.clkin(clkin), .reset_rising(reset_rising), .sysclk(sysclk), .play(play),
		.pgm_we_n(pgm_we_n), .pgm_address(pgm_address), .pgm_data(pgm_data),
		.volume(volume), .vol_latch(vol_latch), .sdout(sdout), .lrck(lrck),
		.bclk(bclk), .mclk(mclk), .dac_status(dac_status),
		.error_count(error_count), .sample_count(sample_count)
	);

	initial begin
		clkin = 1'b0;
		forever #10 clkin = ~clkin;
	end

	// Slow system clock, six clkin per period
	initial begin
		@(negedge reset_rising);
		forever begin
			repeat (3) @(posedge clkin);
			sysclk <= ~sysclk;
		end
	end

	// Random bytes into a range of buffer words
	task automatic fill_words(input int first_word, input int last_word);
		for (int a = first_word * 4; a < (last_word + 1) * 4; a++) begin
			@(posedge clkin);
			pgm_we_n <= 1'b0;
			pgm_address <= pgm_addr_t'(a);
			pgm_data <= 8'($urandom());
		end
		@(posedge clkin);
		pgm_we_n <= 1'b1;
	endtask

	task automatic wait_frames(input int n);
		repeat (n) @(posedge lrck);
	endtask

	// Latch well inside the left half, away from any ramp step
	task automatic latch_volume(input vol_t v);
		@(negedge lrck);
		repeat (200) @(posedge clkin);
		volume <= v;
		vol_latch <= 1'b1;
		repeat (6) @(posedge clkin);
		vol_latch <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'h9ec5));
		reset_rising = 1'b1;
		sysclk = 1'b0;
		pgm_we_n = 1'b1;
		pgm_address = '0;
		pgm_data = 8'h00;
		volume = 8'h00;
		vol_latch = 1'b0;
		play = 1'b0;
		repeat (8) @(posedge clkin);
		reset_rising <= 1'b0;
		fill_words(0, 511);
		wait_frames(4);          // Play low, word 0 only
		@(posedge clkin);
		play <= 1'b1;
		wait_frames(10);
		fill_words(20, 40);      // Words not yet reached by playback
		wait_frames(4);
		latch_volume(8'd2);      // Ramp down
		wait_frames(14);
		latch_volume(8'd200);    // And back up
		wait_frames(12);
		$display("Samples checked %0d, errors %0d", sample_count, error_count);
		if (sample_count < 40)
			$display("Too few serial samples were captured");
		if (error_count == 0 && sample_count >= 40) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// Watchdog, 60 frames of 2048 clocks plus margin
	initial begin
		repeat ((60 * 2048) + 4096) @(posedge clkin);
		$display("Timeout, the run did not finish within 60 frames");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
